// File: common/fifo_loopback_pkg.sv
package fifo_loopback_pkg;

   // **********************************************************************
   // Sizes
   // **********************************************************************
   localparam int DATA_W       = 64;                       // Host word width
   localparam int NUM_CHANNELS = 4;                        // Total FIFO channels
   localparam int CHAN_W       = 2;                        // Bits in a channel number
   localparam int FIFO_DEPTH   = 16;                       // Entries in each FIFO
   localparam int COUNT_W      = 5;                        // Occupancy 0..FIFO_DEPTH

   // **********************************************************************
   // Channel map
   // **********************************************************************
   localparam int CH_LOOP_IN    = 0;                       // Host to loopback
   localparam int CH_SEQ_IN     = 1;                       // Host to sequencer commands
   localparam int CH_LOOP_OUT   = 2;                       // Loopback back to host
   localparam int CH_SEQ_OUT    = 3;                       // Sequencer responses
   localparam int FIRST_TO_HOST = 2;                       // Lowest to-host channel
   localparam int NUM_TO_HOST   = NUM_CHANNELS - FIRST_TO_HOST;

   // Command opcodes, carried in the top byte of a command word
   localparam logic [7:0] OP_ECHO = 8'h01;
   localparam logic [7:0] OP_RAMP = 8'h02;

   // Sequencer FSM state codes
   localparam logic [1:0] ST_IDLE   = 2'd0;
   localparam logic [1:0] ST_DECODE = 2'd1;
   localparam logic [1:0] ST_EMIT   = 2'd2;

   // One command word. The opcode sits in the same byte in both views, so
   // the decoder may look at either one before it knows the command type
   typedef union packed
   {
      struct packed
      {
         logic [7:0]  opcode;
         logic [15:0] count;                               // Words to produce
         logic [7:0]  step;                                // Added after each word
         logic [31:0] start;                               // First ramp value
      } ramp;
      struct packed
      {
         logic [7:0]  opcode;
         logic [55:0] payload;                             // Returned with opcode cleared
      } echo;
   } seq_cmd_t;

endpackage

// File: design/sync_fifo.sv
module sync_fifo
(
   input  logic                                clock,
   input  logic                                rst_n,
   input  logic                                wr_en,
   input  logic [fifo_loopback_pkg::DATA_W-1:0] wr_data,
   input  logic                                rd_en,
   output logic [fifo_loopback_pkg::DATA_W-1:0] rd_data,
   output logic                                nonempty,
   output logic                                space
);
   import fifo_loopback_pkg::*;

   // Pointers are one bit narrower than the count and wrap on their own
   logic [DATA_W-1:0]  mem [FIFO_DEPTH];
   logic [COUNT_W-2:0] wr_ptr;
   logic [COUNT_W-2:0] rd_ptr;
   logic [COUNT_W-1:0] count;

   // **********************************************************************
   // Storage
   // **********************************************************************
   always_ff @(posedge clock)
   begin
      if (wr_en)
         mem[wr_ptr] <= wr_data;                            // No reset on the array
   end

   // Head of the queue falls straight through to the output
   assign rd_data  = mem[rd_ptr];
   assign nonempty = (count != '0);

   // Two free entries are kept back so that a producer with one write
   // already registered can never overrun the buffer
   assign space = (count <= COUNT_W'(FIFO_DEPTH - 2));

   // **********************************************************************
   // Pointers and occupancy
   // **********************************************************************
   always_ff @(posedge clock or negedge rst_n)
   begin
      if (!rst_n)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (wr_en)
            wr_ptr <= wr_ptr + 1'b1;
         if (rd_en)
            rd_ptr <= rd_ptr + 1'b1;                        // Callers pop only when nonempty

         // Simultaneous push and pop leaves the count alone
         case ({wr_en, rd_en})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

// File: host_port/host_write_demux.sv
module host_write_demux
(
   input  logic                                      clock,
   input  logic                                      rst_n,
   input  logic                                      host_wr_valid,
   input  logic [fifo_loopback_pkg::CHAN_W-1:0]       host_wr_chan,
   input  logic [fifo_loopback_pkg::DATA_W-1:0]       host_wr_data,
   input  logic [fifo_loopback_pkg::NUM_CHANNELS-1:0] chan_space,
   output logic [fifo_loopback_pkg::NUM_CHANNELS-1:0] fifo_wr_en,
   output logic [fifo_loopback_pkg::DATA_W-1:0]       fifo_wr_data,
   output logic                                      host_wr_error
);
   import fifo_loopback_pkg::*;

   logic accept;                                            // Strobe may go to a FIFO

   // Only from-host channels take host data, and only with room left
   assign accept = (host_wr_chan < CHAN_W'(FIRST_TO_HOST)) && chan_space[host_wr_chan];

   always_ff @(posedge clock or negedge rst_n)
   begin
      if (!rst_n)
      begin
         fifo_wr_en    <= '0;
         host_wr_error <= 1'b0;
      end
      else
      begin
         fifo_wr_en    <= '0;                              // Both outputs are single pulses
         host_wr_error <= 1'b0;
         if (host_wr_valid)
         begin
            if (accept)
               fifo_wr_en[host_wr_chan] <= 1'b1;
            else
               host_wr_error <= 1'b1;                       // Word is dropped here
         end
      end
   end

   // One data register serves every channel since only one enable fires
   always_ff @(posedge clock)
   begin
      if (host_wr_valid)
         fifo_wr_data <= host_wr_data;
   end

endmodule

// File: host_port/host_read_arbiter.sv
module host_read_arbiter
(
   input  logic                                      clock,
   input  logic                                      rst_n,
   input  logic                                      host_rd_ready,
   input  logic [fifo_loopback_pkg::NUM_CHANNELS-1:0] chan_nonempty,
   input  logic [fifo_loopback_pkg::NUM_CHANNELS*fifo_loopback_pkg::DATA_W-1:0] chan_rd_data,
   output logic [fifo_loopback_pkg::NUM_CHANNELS-1:0] fifo_rd_en,
   output logic                                      host_rd_valid,
   output logic [fifo_loopback_pkg::CHAN_W-1:0]       host_rd_chan,
   output logic [fifo_loopback_pkg::DATA_W-1:0]       host_rd_data
);
   import fifo_loopback_pkg::*;

   logic [CHAN_W-1:0] last_grant;                           // Channel served most recently
   logic [CHAN_W-1:0] grant_chan;
   logic [CHAN_W-1:0] cand;
   logic              grant_found;
   logic              pop;

   // **********************************************************************
   // Round-robin pick over the to-host channels
   // **********************************************************************
   always_comb
   begin
      grant_found = 1'b0;
      grant_chan  = last_grant;
      cand        = last_grant;
      for (int i = 1; i <= NUM_TO_HOST; i++)
      begin
         // Start one past the last grant and wrap inside the to-host range
         cand = CHAN_W'(FIRST_TO_HOST + (int'(last_grant) - FIRST_TO_HOST + i) % NUM_TO_HOST);
         if (!grant_found && chan_nonempty[cand])
         begin
            grant_found = 1'b1;
            grant_chan  = cand;
         end
      end
   end

   assign pop = host_rd_ready && grant_found;               // Host ready level gates every pop

   always_comb
   begin
      fifo_rd_en = '0;
      if (pop)
         fifo_rd_en[grant_chan] = 1'b1;
   end

   // **********************************************************************
   // Output register
   // **********************************************************************
   always_ff @(posedge clock or negedge rst_n)
   begin
      if (!rst_n)
      begin
         last_grant    <= CHAN_W'(NUM_CHANNELS - 1);        // First pick lands on FIRST_TO_HOST
         host_rd_valid <= 1'b0;
      end
      else
      begin
         host_rd_valid <= pop;
         if (pop)
            last_grant <= grant_chan;
      end
   end

   // Word and tag are captured from the FIFO head on the pop cycle
   always_ff @(posedge clock)
   begin
      if (pop)
      begin
         host_rd_chan <= grant_chan;
         host_rd_data <= chan_rd_data[grant_chan*DATA_W +: DATA_W];
      end
   end

endmodule

// File: design/loopback_user.sv
module loopback_user
(
   input  logic                                clock,
   input  logic                                rst_n,
   input  logic                                in_nonempty,
   input  logic [fifo_loopback_pkg::DATA_W-1:0] in_data,
   output logic                                in_rd_en,
   input  logic                                out_space,
   output logic                                out_wr_en,
   output logic [fifo_loopback_pkg::DATA_W-1:0] out_wr_data,
   output logic [3:0]                          led
);

   // Pop whenever a word waits and the return FIFO can absorb one more
   assign in_rd_en = in_nonempty && out_space;

   always_ff @(posedge clock or negedge rst_n)
   begin
      if (!rst_n)
      begin
         out_wr_en <= 1'b0;
         led       <= 4'h5;                                 // Alternating pattern until data arrives
      end
      else
      begin
         out_wr_en <= in_rd_en;                             // Write lands one cycle after the pop
         if (in_rd_en)
            led <= in_data[3:0];
      end
   end

   // Payload follows the popped head without a reset
   always_ff @(posedge clock)
   begin
      if (in_rd_en)
         out_wr_data <= in_data;
   end

endmodule

// File: sequencer/command_sequencer.sv
module command_sequencer
(
   input  logic                                clock,
   input  logic                                rst_n,
   input  logic                                cmd_nonempty,
   input  logic [fifo_loopback_pkg::DATA_W-1:0] cmd_data,
   output logic                                cmd_rd_en,
   input  logic                                rsp_space,
   output logic                                rsp_wr_en,
   output logic [fifo_loopback_pkg::DATA_W-1:0] rsp_wr_data
);
   import fifo_loopback_pkg::*;

   logic [1:0]  state;
   seq_cmd_t    cmd;                                        // Command under execution
   logic [15:0] remaining;                                  // Words still to write
   logic [31:0] accum;                                      // Next ramp value
   logic        is_echo;
   logic        emit;

   // Commands are taken one at a time, only from idle
   assign cmd_rd_en = (state == ST_IDLE) && cmd_nonempty;
   assign is_echo   = (cmd.echo.opcode == OP_ECHO);
   assign emit      = (state == ST_EMIT) && rsp_space;      // Stall while the response FIFO is full

   // **********************************************************************
   // FSM and word count
   // **********************************************************************
   always_ff @(posedge clock or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state     <= ST_IDLE;
         remaining <= '0;
         rsp_wr_en <= 1'b0;
      end
      else
      begin
         rsp_wr_en <= emit;
         case (state)
            ST_IDLE:
            begin
               if (cmd_rd_en)
                  state <= ST_DECODE;
            end
            ST_DECODE:
            begin
               // Zero count and unknown opcodes go straight back to idle
               if (is_echo)
               begin
                  remaining <= 16'd1;
                  state     <= ST_EMIT;
               end
               else if (cmd.ramp.opcode == OP_RAMP && cmd.ramp.count != '0)
               begin
                  remaining <= cmd.ramp.count;
                  state     <= ST_EMIT;
               end
               else
                  state <= ST_IDLE;
            end
            ST_EMIT:
            begin
               if (emit)
               begin
                  remaining <= remaining - 1'b1;
                  if (remaining == 16'd1)
                     state <= ST_IDLE;                      // Last word of this command
               end
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   // **********************************************************************
   // Command hold, ramp value and response word
   // **********************************************************************
   always_ff @(posedge clock)
   begin
      if (cmd_rd_en)
         cmd <= cmd_data;
      if (state == ST_DECODE)
         accum <= cmd.ramp.start;                           // Loaded for echo too, unused there
      else if (emit)
         accum <= accum + 32'(cmd.ramp.step);               // Wraps modulo 2**32
      if (emit)
      begin
         if (is_echo)
            rsp_wr_data <= {8'h00, cmd.echo.payload};
         else
            rsp_wr_data <= {32'h0, accum};
      end
   end

endmodule

// File: design/fifo_loopback_top.sv
module fifo_loopback_top
(
   input  logic                                      clock,
   input  logic                                      rst_n,
   input  logic                                      host_wr_valid,
   input  logic [fifo_loopback_pkg::CHAN_W-1:0]       host_wr_chan,
   input  logic [fifo_loopback_pkg::DATA_W-1:0]       host_wr_data,
   output logic [fifo_loopback_pkg::NUM_CHANNELS-1:0] host_wr_space,
   output logic                                      host_wr_error,
   input  logic                                      host_rd_ready,
   output logic                                      host_rd_valid,
   output logic [fifo_loopback_pkg::CHAN_W-1:0]       host_rd_chan,
   output logic [fifo_loopback_pkg::DATA_W-1:0]       host_rd_data,
   output logic [3:0]                                led
);
   import fifo_loopback_pkg::*;

   // Host side of the FIFOs
   logic [NUM_CHANNELS-1:0]        demux_wr_en;
   logic [DATA_W-1:0]              demux_wr_data;
   logic [NUM_CHANNELS-1:0]        arb_rd_en;
   logic [NUM_CHANNELS*DATA_W-1:0] ch_rd_flat;

   // User side, one slot per channel, unused slots tied off below
   logic [NUM_CHANNELS-1:0] usr_wr_en;
   logic [NUM_CHANNELS-1:0] usr_rd_en;
   logic [DATA_W-1:0]       usr_wr_data [NUM_CHANNELS];

   // Per-channel FIFO ports
   logic [NUM_CHANNELS-1:0] ch_nonempty;
   logic [DATA_W-1:0]       ch_rd_data [NUM_CHANNELS];

   assign usr_wr_en[CH_LOOP_IN]    = 1'b0;
   assign usr_wr_en[CH_SEQ_IN]     = 1'b0;
   assign usr_rd_en[CH_LOOP_OUT]   = 1'b0;
   assign usr_rd_en[CH_SEQ_OUT]    = 1'b0;
   assign usr_wr_data[CH_LOOP_IN]  = '0;
   assign usr_wr_data[CH_SEQ_IN]   = '0;

   host_write_demux u_demux
   (
      .clock(clock), .rst_n(rst_n),
      .host_wr_valid(host_wr_valid), .host_wr_chan(host_wr_chan), .host_wr_data(host_wr_data),
      .chan_space(host_wr_space), .fifo_wr_en(demux_wr_en), .fifo_wr_data(demux_wr_data),
      .host_wr_error(host_wr_error)
   );

   // **********************************************************************
   // Channel FIFOs. Host writes and user reads below FIRST_TO_HOST, the
   // reverse from there up; the idle side of every enable stays low
   // **********************************************************************
   for (genvar ch = 0; ch < NUM_CHANNELS; ch++)
   begin : g_chan
      sync_fifo u_fifo
      (
         .clock(clock), .rst_n(rst_n),
         .wr_en(demux_wr_en[ch] | usr_wr_en[ch]),
         .wr_data((ch < FIRST_TO_HOST) ? demux_wr_data : usr_wr_data[ch]),
         .rd_en(arb_rd_en[ch] | usr_rd_en[ch]),
         .rd_data(ch_rd_data[ch]), .nonempty(ch_nonempty[ch]), .space(host_wr_space[ch])
      );
      assign ch_rd_flat[ch*DATA_W +: DATA_W] = ch_rd_data[ch];
   end

   host_read_arbiter u_arbiter
   (
      .clock(clock), .rst_n(rst_n), .host_rd_ready(host_rd_ready),
      .chan_nonempty(ch_nonempty), .chan_rd_data(ch_rd_flat), .fifo_rd_en(arb_rd_en),
      .host_rd_valid(host_rd_valid), .host_rd_chan(host_rd_chan), .host_rd_data(host_rd_data)
   );

   loopback_user u_loopback
   (
      .clock(clock), .rst_n(rst_n),
      .in_nonempty(ch_nonempty[CH_LOOP_IN]), .in_data(ch_rd_data[CH_LOOP_IN]),
      .in_rd_en(usr_rd_en[CH_LOOP_IN]), .out_space(host_wr_space[CH_LOOP_OUT]),
      .out_wr_en(usr_wr_en[CH_LOOP_OUT]), .out_wr_data(usr_wr_data[CH_LOOP_OUT]), .led(led)
   );

   command_sequencer u_sequencer
   (
      .clock(clock), .rst_n(rst_n),
      .cmd_nonempty(ch_nonempty[CH_SEQ_IN]), .cmd_data(ch_rd_data[CH_SEQ_IN]),
      .cmd_rd_en(usr_rd_en[CH_SEQ_IN]), .rsp_space(host_wr_space[CH_SEQ_OUT]),
      .rsp_wr_en(usr_wr_en[CH_SEQ_OUT]), .rsp_wr_data(usr_wr_data[CH_SEQ_OUT])
   );

endmodule

// File: tb/fifo_loopback_tb.sv
module fifo_loopback_tb;
   import fifo_loopback_pkg::*;

   logic                    clock;
   logic                    rst_n;
   logic                    host_wr_valid;
   logic [CHAN_W-1:0]       host_wr_chan;
   logic [DATA_W-1:0]       host_wr_data;
   logic [NUM_CHANNELS-1:0] host_wr_space;
   logic                    host_wr_error;
   logic                    host_rd_ready;
   logic                    host_rd_valid;
   logic [CHAN_W-1:0]       host_rd_chan;
   logic [DATA_W-1:0]       host_rd_data;
   logic [3:0]              led;

   logic [31:0]       rng_state;                             // Xorshift state
   logic [DATA_W-1:0] exp_loop [$];                          // Words still due on channel 2
   logic [DATA_W-1:0] exp_seq [$];                           // Words still due on channel 3
   logic [DATA_W-1:0] exp_word;
   logic              err_expected;                          // Error pulse due after this edge
   logic [3:0]        exp_led;
   int                waited;

   fifo_loopback_top UUT
   (
      .clock(clock), .rst_n(rst_n),
      .host_wr_valid(host_wr_valid), .host_wr_chan(host_wr_chan), .host_wr_data(host_wr_data),
      .host_wr_space(host_wr_space), .host_wr_error(host_wr_error),
      .host_rd_ready(host_rd_ready), .host_rd_valid(host_rd_valid),
      .host_rd_chan(host_rd_chan), .host_rd_data(host_rd_data), .led(led)
   );

   always #2 clock = ~clock;

   // **********************************************************************
   // Random numbers and failure reporting
   // **********************************************************************
   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function logic [31:0] next_rand();
      rng_state = xorshift32(rng_state);
      return rng_state;
   endfunction

   task report_mismatch(input string name, input logic [63:0] expected, input logic [63:0] actual);
      $display("error at time %0t: %s expected %h actual %h", $time, name, expected, actual);
      $display("Regression failed");
      $fatal(1);
   endtask

   task report_failure(input string what);
      $display("%s", what);
      $display("Regression failed");
      $fatal(1);
   endtask

   // **********************************************************************
   // Reference model
   // **********************************************************************
   // Pushes every response word that one accepted command should produce
   task automatic expect_response(input logic [DATA_W-1:0] word);
      seq_cmd_t    cmd;
      logic [31:0] value;
      int          i;
      cmd = word;
      if (cmd.echo.opcode == OP_ECHO)
         exp_seq.push_back({8'h00, cmd.echo.payload});       // Opcode byte cleared
      else if (cmd.ramp.opcode == OP_RAMP)
      begin
         value = cmd.ramp.start;
         for (i = 0; i < cmd.ramp.count; i++)
         begin
            exp_seq.push_back({32'h0, value});
            value = value + cmd.ramp.step;                   // Wraps at 32 bits
         end
      end
   endtask

   // Echo, two kinds of ramp, or an opcode the sequencer must ignore
   function logic [DATA_W-1:0] make_command();
      seq_cmd_t    cmd;
      logic [31:0] kind;
      cmd  = {next_rand(), next_rand()};
      kind = next_rand() % 4;
      if (kind == 0)
         cmd.echo.opcode = OP_ECHO;
      else if (kind == 3)
         cmd.ramp.opcode = 8'h80 | cmd.ramp.opcode;          // Never 01 or 02
      else
      begin
         cmd.ramp.opcode = OP_RAMP;
         cmd.ramp.count  = 16'(next_rand() % 21);            // Zero included
      end
      return cmd;
   endfunction

   // **********************************************************************
   // Cycle helpers
   // **********************************************************************
   // Moves to just after the next rising edge and checks the error pulse
   task advance_cycle();
      @(posedge clock);
      #1;
      assert (host_wr_error == err_expected)
      else report_mismatch("host_wr_error", err_expected, host_wr_error);
   endtask

   task apply_inputs(input logic valid, input logic [CHAN_W-1:0] chan,
                     input logic [DATA_W-1:0] data, input logic ready);
      logic accept;
      accept        = valid && (chan < FIRST_TO_HOST) && host_wr_space[chan];
      err_expected  = valid && !accept;                      // Bad channel or no room
      host_wr_valid = valid;
      host_wr_chan  = chan;
      host_wr_data  = data;
      host_rd_ready = ready;
      if (accept && chan == CH_LOOP_IN)
      begin
         exp_loop.push_back(data);
         exp_led = data[3:0];
      end
      if (accept && chan == CH_SEQ_IN)
         expect_response(data);
   endtask

   // Every FIFO is empty, so every channel reports room
   task check_reset_outputs();
      assert (host_rd_valid == 1'b0) else report_mismatch("host_rd_valid", 0, host_rd_valid);
      assert (host_wr_error == 1'b0) else report_mismatch("host_wr_error", 0, host_wr_error);
      assert (led == 4'h5) else report_mismatch("led", 4'h5, led);
      assert (host_wr_space == 4'hf)
      else report_mismatch("host_wr_space", 4'hf, host_wr_space);
   endtask

   task random_cycle();
      logic [31:0]       r;
      logic [2:0]        sel;
      logic [CHAN_W-1:0] chan;
      logic              valid;
      logic              ready;
      logic [DATA_W-1:0] data;
      advance_cycle();
      r     = next_rand();
      ready = (next_rand() % 10) < 6;                        // About 60% ready
      valid = r[0];
      sel   = r[4:2];
      chan  = (sel < 3) ? CHAN_W'(CH_LOOP_IN) : (sel < 6) ? CHAN_W'(CH_SEQ_IN) : CHAN_W'(sel - 4);
      // Only one write in eight to a full channel goes ahead and overflows it
      if (valid && chan < FIRST_TO_HOST && !host_wr_space[chan] && r[7:5] != 3'd0)
         valid = 1'b0;
      data = (chan == CH_SEQ_IN) ? make_command() : {next_rand(), next_rand()};
      apply_inputs(valid, chan, data, ready);
   endtask

   // **********************************************************************
   // Read side monitor, sampled on the falling edge
   // **********************************************************************
   always @(negedge clock)
   begin
      if (rst_n && host_rd_valid)
      begin
         assert (host_rd_chan == CH_LOOP_OUT || host_rd_chan == CH_SEQ_OUT)
         else report_mismatch("host_rd_chan", 2'b10, host_rd_chan);
         if (host_rd_chan == CH_LOOP_OUT)
         begin
            assert (exp_loop.size() > 0)
            else report_failure("A word arrived on channel 2 when none was expected");
            exp_word = exp_loop.pop_front();
         end
         else
         begin
            assert (exp_seq.size() > 0)
            else report_failure("A word arrived on channel 3 when none was expected");
            exp_word = exp_seq.pop_front();
         end
         assert (host_rd_data == exp_word)
         else report_mismatch("host_rd_data", exp_word, host_rd_data);
      end
   end

   // **********************************************************************
   // Test sequence
   // **********************************************************************
   initial
   begin
      clock         = 1'b0;
      rst_n         = 1'b0;
      host_wr_valid = 1'b0;
      host_wr_chan  = '0;
      host_wr_data  = '0;
      host_rd_ready = 1'b0;
      rng_state     = 32'ha2f2;
      err_expected  = 1'b0;
      exp_led       = 4'h5;                                  // Reset pattern until a word passes
      repeat (5)
      begin
         advance_cycle();
         check_reset_outputs();
      end
      rst_n = 1'b1;
      advance_cycle();
      check_reset_outputs();

      repeat (1500) random_cycle();

      // Host stops reading so channel 0 backs up and its space drops
      waited = 0;
      advance_cycle();
      while (host_wr_space[CH_LOOP_IN])
      begin
         waited++;
         if (waited > 200)
            report_failure("Timeout while waiting for channel 0 space to drop");
         apply_inputs(1'b1, CHAN_W'(CH_LOOP_IN), {next_rand(), next_rand()}, 1'b0);
         advance_cycle();
      end
      apply_inputs(1'b1, CHAN_W'(CH_LOOP_IN), {next_rand(), next_rand()}, 1'b0);   // Overflow
      advance_cycle();
      apply_inputs(1'b1, CHAN_W'(CH_LOOP_OUT), {next_rand(), next_rand()}, 1'b0);  // Illegal
      advance_cycle();
      apply_inputs(1'b1, CHAN_W'(CH_SEQ_OUT), {next_rand(), next_rand()}, 1'b0);   // Illegal
      advance_cycle();
      apply_inputs(1'b0, '0, '0, 1'b0);

      repeat (1500) random_cycle();

      // Drain with the host always ready
      waited = 0;
      while (exp_loop.size() > 0 || exp_seq.size() > 0)
      begin
         waited++;
         if (waited > 3000)
            report_failure("Timeout while waiting for the expected words to drain");
         advance_cycle();
         apply_inputs(1'b0, '0, '0, 1'b1);
      end
      repeat (60)                                            // Any stray word trips the monitor
      begin
         advance_cycle();
         apply_inputs(1'b0, '0, '0, 1'b1);
      end
      assert (led == exp_led) else report_mismatch("led", exp_led, led);
      $display("Regression passed");
      $finish;
   end

endmodule

// File: fifo_loopback.f
common/fifo_loopback_pkg.sv
design/sync_fifo.sv
host_port/host_write_demux.sv
host_port/host_read_arbiter.sv
design/loopback_user.sv
sequencer/command_sequencer.sv
design/fifo_loopback_top.sv
tb/fifo_loopback_tb.sv
